/* all.f */
+incdir+.
cfu_pkg.sv
cfu_instr_ram.sv
cfu_data_ram.sv
cfu_cmd_fsm.sv
cfu.sv
tb_cfu.sv

/* cfu.sv */
// CFU top level: command FSM, instruction RAM and compute RAM banks
`timescale 1ns/1ps

module cfu (
  input  logic clk,
  input  logic resetn,
  // Command from the CPU
  input  logic cmd_valid,
  output logic cmd_ready,
  input  logic [9:0] cmd_function_id,
  input  logic [31:0] cmd_inputs_0,
  input  logic [31:0] cmd_inputs_1,
  // Response to the CPU
  output logic rsp_valid,
  input  logic rsp_ready,
  output logic [31:0] rsp_outputs_0
);

  // Instruction RAM port
  logic instr_we;
  logic [cfu_pkg::awidth-1:0] instr_addr;
  logic [31:0] instr_wdata;
  logic [31:0] instr_rdata;

  // Compute RAM ports
  logic cram_we;
  logic [cfu_pkg::log_num_crams-1:0] cram_bank;
  logic [cfu_pkg::awidth-1:0] cram_addr;
  logic [cfu_pkg::dwidth-1:0] cram_wdata;
  logic [cfu_pkg::log_num_crams-1:0] cram_rd_bank;
  logic [cfu_pkg::awidth-1:0] cram_rd_addr;
  logic [cfu_pkg::dwidth-1:0] cram_rdata;

  // Handshake, decode and result select
  cfu_cmd_fsm u_cmd_fsm (
    .clk(clk),
    .resetn(resetn),
    .cmd_valid(cmd_valid),
    .cmd_ready(cmd_ready),
    .cmd_function_id(cmd_function_id),
    .cmd_inputs_0(cmd_inputs_0),
    .cmd_inputs_1(cmd_inputs_1),
    .rsp_valid(rsp_valid),
    .rsp_ready(rsp_ready),
    .rsp_outputs_0(rsp_outputs_0),
    .instr_we(instr_we),
    .instr_addr(instr_addr),
    .instr_wdata(instr_wdata),
    .instr_rdata(instr_rdata),
    .cram_we(cram_we),
    .cram_bank(cram_bank),
    .cram_addr(cram_addr),
    .cram_wdata(cram_wdata),
    .cram_rd_bank(cram_rd_bank),
    .cram_rd_addr(cram_rd_addr),
    .cram_rdata(cram_rdata)
  );

  // Instruction store
  cfu_instr_ram u_instr_ram (
    .clk(clk),
    .we(instr_we),
    .addr(instr_addr),
    .wdata(instr_wdata),
    .rdata(instr_rdata)
  );

  // Compute RAM banks
  cfu_data_ram u_data_ram (
    .clk(clk),
    .we(cram_we),
    .bank(cram_bank),
    .addr(cram_addr),
    .wdata(cram_wdata),
    .rd_bank(cram_rd_bank),
    .rd_addr(cram_rd_addr),
    .rdata(cram_rdata)
  );

endmodule

/* cfu_cmd_fsm.sv */
// Command handshake FSM with input registers, byte add,
// RAM strobe generation and response select
`timescale 1ns/1ps

module cfu_cmd_fsm (
  input  logic clk,
  input  logic resetn,
  // CPU command side
  input  logic cmd_valid,
  output logic cmd_ready,
  input  logic [9:0] cmd_function_id,
  input  logic [31:0] cmd_inputs_0,
  input  logic [31:0] cmd_inputs_1,
  // CPU response side
  output logic rsp_valid,
  input  logic rsp_ready,
  output logic [31:0] rsp_outputs_0,
  // Instruction RAM port
  output logic instr_we,
  output logic [cfu_pkg::awidth-1:0] instr_addr,
  output logic [31:0] instr_wdata,
  input  logic [31:0] instr_rdata,
  // Compute RAM ports
  output logic cram_we,
  output logic [cfu_pkg::log_num_crams-1:0] cram_bank,
  output logic [cfu_pkg::awidth-1:0] cram_addr,
  output logic [cfu_pkg::dwidth-1:0] cram_wdata,
  output logic [cfu_pkg::log_num_crams-1:0] cram_rd_bank,
  output logic [cfu_pkg::awidth-1:0] cram_rd_addr,
  input  logic [cfu_pkg::dwidth-1:0] cram_rdata
);

  logic [1:0] state;
  logic accept;
  logic is_read;

  // Registered command
  logic [9:0] func_q;
  logic [31:0] in0_q;
  cfu_pkg::cram_word_u in1_q;
  logic [2:0] funct3_q;
  logic [6:0] funct7_q;

  logic [8:0] byte_sum;
  logic [31:0] result;

  // Handshake on the edge where both are high
  assign accept = cmd_valid && cmd_ready;

  // funct3 low, funct7 high
  assign funct3_q = func_q[2:0];
  assign funct7_q = func_q[9:3];

  // Reads need one more cycle for the registered RAM output
  assign is_read = (funct3_q == cfu_pkg::op_instr_rd) ||
                   (funct3_q == cfu_pkg::op_cram_rd);

  ////////////////////////////////////////
  // Handshake FSM
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= cfu_pkg::st_idle;
      cmd_ready <= 1'b1;
      rsp_valid <= 1'b0;
    end else begin
      case (state)
        cfu_pkg::st_idle: begin
          if (accept) begin
            state <= cfu_pkg::st_issue;
            cmd_ready <= 1'b0;
          end else begin
            // Reopen one edge after the response completed
            cmd_ready <= 1'b1;
          end
        end
        cfu_pkg::st_issue: begin
          state <= is_read ? cfu_pkg::st_wait : cfu_pkg::st_resp;
        end
        cfu_pkg::st_wait: begin
          state <= cfu_pkg::st_resp;
        end
        cfu_pkg::st_resp: begin
          // First cycle in respond raises rsp_valid
          if (!rsp_valid) begin
            rsp_valid <= 1'b1;
          end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
            state <= cfu_pkg::st_idle;
          end
        end
        default: begin
          state <= cfu_pkg::st_idle;
        end
      endcase
    end
  end

  // Command payload, captured on acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      func_q <= cmd_function_id;
      in0_q <= cmd_inputs_0;
      in1_q.raw <= cmd_inputs_1;
    end
  end

  // Response payload, loaded together with rsp_valid
  always_ff @(posedge clk) begin
    if (state == cfu_pkg::st_resp && !rsp_valid) begin
      rsp_outputs_0 <= result;
    end
  end

  ////////////////////////////////////////
  // RAM strobes and addresses
  ////////////////////////////////////////

  // Write strobes pulse for the single issue cycle
  assign instr_we = (state == cfu_pkg::st_issue) && (funct3_q == cfu_pkg::op_instr_wr);
  assign cram_we = (state == cfu_pkg::st_issue) && (funct3_q == cfu_pkg::op_cram_wr);

  // Instruction RAM: address in inputs_0, data in inputs_1
  assign instr_addr = in0_q[cfu_pkg::awidth-1:0];
  assign instr_wdata = in1_q.raw;

  // Compute RAM: bank and address in inputs_1, word split across both inputs
  assign cram_bank = in1_q.cram.bank;
  assign cram_addr = in1_q.cram.addr;
  assign cram_wdata = {in1_q.cram.data_hi, in0_q};
  assign cram_rd_bank = in1_q.cram.bank;
  assign cram_rd_addr = in1_q.cram.addr;

  ////////////////////////////////////////
  // Result select
  ////////////////////////////////////////

  // Nine bits keep the carry out of the byte add
  assign byte_sum = in0_q[7:0] + in1_q.raw[7:0];

  always_comb begin
    case (funct3_q)
      cfu_pkg::op_add: result = {23'b0, byte_sum};
      cfu_pkg::op_instr_wr: result = {32{1'b1}};
      cfu_pkg::op_instr_rd: result = instr_rdata;
      cfu_pkg::op_cram_wr: result = {32{1'b1}};
      cfu_pkg::op_cram_rd: begin
        // funct7 picks the low word or the zero-extended top byte
        if (funct7_q == 7'd0) begin
          result = cram_rdata[31:0];
        end else if (funct7_q == 7'd1) begin
          result = {{(64 - cfu_pkg::dwidth){1'b0}}, cram_rdata[cfu_pkg::dwidth-1:32]};
        end else begin
          result = 32'b0;
        end
      end
      default: result = 32'b0;
    endcase
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Only one command in flight
  assert property (@(posedge clk) disable iff (!resetn) !(cmd_ready && rsp_valid));

  // Back-pressure holds the response
  assert property (@(posedge clk) disable iff (!resetn)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_outputs_0));

endmodule

/* cfu_data_ram.sv */
// Four compute RAM banks, 512 x 40 each, with bank write decode
// and a registered read selected by bank
`timescale 1ns/1ps

module cfu_data_ram (
  input  logic clk,
  // Write port, bank plus word address
  input  logic we,
  input  logic [cfu_pkg::log_num_crams-1:0] bank,
  input  logic [cfu_pkg::awidth-1:0] addr,
  input  logic [cfu_pkg::dwidth-1:0] wdata,
  // Read port, bank plus word address
  input  logic [cfu_pkg::log_num_crams-1:0] rd_bank,
  input  logic [cfu_pkg::awidth-1:0] rd_addr,
  output logic [cfu_pkg::dwidth-1:0] rdata
);

  // One write enable per bank
  logic [cfu_pkg::num_crams-1:0] bank_we;

  // Registered read of every bank
  logic [cfu_pkg::dwidth-1:0] bank_q [cfu_pkg::num_crams];

  // Bank select follows the read data by one cycle
  logic [cfu_pkg::log_num_crams-1:0] rd_bank_q;

  ////////////////////////////////////////
  // Bank arrays
  ////////////////////////////////////////

  for (genvar g = 0; g < cfu_pkg::num_crams; g++) begin : g_bank
    logic [cfu_pkg::dwidth-1:0] mem [cfu_pkg::num_words];

    // Decode the target bank
    assign bank_we[g] = we && (bank == cfu_pkg::log_num_crams'(g));

    always_ff @(posedge clk) begin
      if (bank_we[g]) begin
        mem[addr] <= wdata;
      end
    end

    // All banks read the same address every cycle
    always_ff @(posedge clk) begin
      bank_q[g] <= mem[rd_addr];
    end
  end

  ////////////////////////////////////////
  // Read select
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    rd_bank_q <= rd_bank;
  end

  // Mux after the bank registers
  assign rdata = bank_q[rd_bank_q];

  // Strobe comes out of reset on the first edge, checked from the next one on
  assert property (@(posedge clk) ##1 !$isunknown(we));

endmodule

/* cfu_instr_ram.sv */
// Single-port instruction RAM, 512 x 32, registered read
`timescale 1ns/1ps

module cfu_instr_ram (
  input  logic clk,
  input  logic we,
  input  logic [cfu_pkg::awidth-1:0] addr,
  input  logic [31:0] wdata,
  output logic [31:0] rdata
);

  // Storage, no reset
  logic [31:0] mem [cfu_pkg::num_words];

  // Write port
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
  end

  // Read-first registered output
  // Data for an address shows one cycle after it is presented
  always_ff @(posedge clk) begin
    rdata <= mem[addr];
  end

  // A write must land on a known word
  assert property (@(posedge clk) we |-> !$isunknown(addr));

endmodule

/* cfu_pkg.sv */
// Shared widths, RAM geometry, funct3 opcodes, FSM state codes
// and the inputs_1 command word union
package cfu_pkg;

  ////////////////////////////////////////
  // RAM geometry
  ////////////////////////////////////////

  // Compute RAM word width
  localparam int dwidth = 40;
  // Address width of every RAM
  localparam int awidth = 9;
  // Depth of every RAM
  localparam int num_words = 512;
  // Bank select width and bank count
  localparam int log_num_crams = 2;
  localparam int num_crams = 4;

  ////////////////////////////////////////
  // funct3 opcodes
  ////////////////////////////////////////

  // Byte add of the low bytes
  localparam logic [2:0] op_add = 3'd0;
  // Instruction RAM write and read
  localparam logic [2:0] op_instr_wr = 3'd3;
  localparam logic [2:0] op_instr_rd = 3'd4;
  // Compute RAM write and read
  localparam logic [2:0] op_cram_wr = 3'd5;
  localparam logic [2:0] op_cram_rd = 3'd6;

  ////////////////////////////////////////
  // Command FSM state codes
  ////////////////////////////////////////

  // Waiting for a command
  localparam logic [1:0] st_idle = 2'd0;
  // Strobes go out to the RAMs
  localparam logic [1:0] st_issue = 2'd1;
  // Extra cycle for a registered RAM read
  localparam logic [1:0] st_wait = 2'd2;
  // Response held until rsp_ready
  localparam logic [1:0] st_resp = 2'd3;

  ////////////////////////////////////////
  // inputs_1 command word
  ////////////////////////////////////////

  // Raw view carries instruction RAM write data
  // Cram view carries bank, word address and data bits 39:32
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [31-log_num_crams-awidth-(dwidth-32):0] unused;
      logic [log_num_crams-1:0] bank;
      logic [awidth-1:0] addr;
      logic [dwidth-33:0] data_hi;
    } cram;
  } cram_word_u;

endpackage

/* tb_cfu_table.svh */
// Stimulus and expected value table for the CFU testbench
// Columns per entry: funct7, funct3, inputs_0, inputs_1, expected result, stall cycles
`ifndef TB_CFU_TABLE_SVH
`define TB_CFU_TABLE_SVH

typedef struct packed {
  logic [6:0] funct7;
  logic [2:0] funct3;
  logic [31:0] in0;
  logic [31:0] in1;
  logic [31:0] expected;
  logic [3:0] stall;
} entry_t;

entry_t stim_q[$];

// Append one command to the table
function automatic void add_entry(input logic [6:0] funct7, input logic [2:0] funct3,
                                  input logic [31:0] in0, input logic [31:0] in1,
                                  input logic [31:0] expected, input logic [3:0] stall);
  entry_t e;
  e.funct7 = funct7;
  e.funct3 = funct3;
  e.in0 = in0;
  e.in1 = in1;
  e.expected = expected;
  e.stall = stall;
  stim_q.push_back(e);
endfunction

// Fill the table, expected values follow the command rules
task automatic build_table();
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] idata [3];
  logic [8:0] iaddr;
  logic [8:0] iaddr_up;
  logic [8:0] iaddr_dn;
  logic [8:0] caddr;
  logic [31:0] lo;
  logic [7:0] hi;
  cfu_pkg::cram_word_u w;
  int k;
  // Byte add, odd entries forced to carry into bit 8
  for (k = 0; k < 6; k++) begin
    a = $random(seed);
    b = $random(seed);
    if (k % 2 == 1) begin
      a[7] = 1'b1;
      b[7] = 1'b1;
    end
    add_entry(7'd0, cfu_pkg::op_add, a, b, 32'(a[7:0]) + 32'(b[7:0]), 4'd0);
  end
  // Upper bits and funct7 play no part in the sum
  add_entry(7'h55, cfu_pkg::op_add, 32'hffff_ffff, 32'h8000_0001, 32'h0000_0100, 4'd0);

  // Instruction RAM, target word and both neighbors
  iaddr = 9'($random(seed));
  iaddr_up = iaddr + 9'd1;
  iaddr_dn = iaddr - 9'd1;
  for (k = 0; k < 3; k++) begin
    idata[k] = $random(seed);
  end
  add_entry(7'd0, cfu_pkg::op_instr_wr, {23'b0, iaddr}, idata[0], 32'hffff_ffff, 4'd0);
  add_entry(7'd0, cfu_pkg::op_instr_wr, {23'b0, iaddr_up}, idata[1], 32'hffff_ffff, 4'd0);
  add_entry(7'd0, cfu_pkg::op_instr_wr, {23'b0, iaddr_dn}, idata[2], 32'hffff_ffff, 4'd0);
  add_entry(7'd0, cfu_pkg::op_instr_rd, {23'b0, iaddr}, 32'd0, idata[0], 4'd0);
  add_entry(7'd0, cfu_pkg::op_instr_rd, {23'b0, iaddr_up}, 32'd0, idata[1], 4'd3);

  // Compute RAM, same address in all banks, distinct words
  caddr = 9'($random(seed));
  lo = $random(seed);
  hi = 8'($random(seed));
  for (k = 0; k < 4; k++) begin
    w.raw = 32'd0;
    w.cram.bank = 2'(k);
    w.cram.addr = caddr;
    w.cram.data_hi = hi + 8'(k);
    add_entry(7'd0, cfu_pkg::op_cram_wr, lo + 32'(k) * 32'h0101_0101, w.raw, 32'hffff_ffff,
              4'd0);
  end
  for (k = 0; k < 4; k++) begin
    w.raw = 32'd0;
    w.cram.bank = 2'(k);
    w.cram.addr = caddr;
    add_entry(7'd0, cfu_pkg::op_cram_rd, 32'd0, w.raw, lo + 32'(k) * 32'h0101_0101, 4'd0);
    add_entry(7'd1, cfu_pkg::op_cram_rd, 32'd0, w.raw, {24'b0, hi + 8'(k)}, 4'd0);
  end

  // Back-pressure on several command kinds
  a = $random(seed);
  b = $random(seed);
  add_entry(7'd0, cfu_pkg::op_add, a, b, 32'(a[7:0]) + 32'(b[7:0]), 4'd5);
  add_entry(7'd1, cfu_pkg::op_cram_rd, 32'd0, w.raw, {24'b0, hi + 8'd3}, 4'd4);
  // Unused opcodes answer zero
  add_entry(7'h7f, 3'd1, $random(seed), $random(seed), 32'd0, 4'd2);
  add_entry(7'd0, 3'd2, $random(seed), $random(seed), 32'd0, 4'd0);
  add_entry(7'h2a, 3'd7, $random(seed), $random(seed), 32'd0, 4'd3);
  // Instruction word survives the compute RAM traffic
  add_entry(7'd0, cfu_pkg::op_instr_rd, {23'b0, iaddr}, 32'd0, idata[0], 4'd0);
endtask

`endif

/* tb_cfu.sv */
// CFU testbench: clock, reset, table loop, command and response
// handshake driver with result, latency and back-pressure checks
`timescale 1ns/1ps

module tb_cfu;

  logic clk;
  logic resetn;
  logic cmd_valid;
  logic cmd_ready;
  logic [9:0] cmd_function_id;
  logic [31:0] cmd_inputs_0;
  logic [31:0] cmd_inputs_1;
  logic rsp_valid;
  logic rsp_ready;
  logic [31:0] rsp_outputs_0;

  // Random stream for data and bus scrambling
  int seed;
  // Edges allowed for any single wait
  int wait_limit = 50;

  `include "tb_cfu_table.svh"

  cfu UUT (
    .clk(clk),
    .resetn(resetn),
    .cmd_valid(cmd_valid),
    .cmd_ready(cmd_ready),
    .cmd_function_id(cmd_function_id),
    .cmd_inputs_0(cmd_inputs_0),
    .cmd_inputs_1(cmd_inputs_1),
    .rsp_valid(rsp_valid),
    .rsp_ready(rsp_ready),
    .rsp_outputs_0(rsp_outputs_0)
  );

  // 10 ns clock
  always #5 clk = ~clk;

  task automatic abort_run();
    $display("TEST FAIL");
    $fatal(1, "Simulation stopped on the first failure");
  endtask

  ////////////////////////////////////////
  // One command through the handshake
  ////////////////////////////////////////

  task automatic apply_entry(input int idx);
    entry_t e;
    int cycles;
    int latency;
    int k;
    logic [31:0] held;
    e = stim_q[idx];
    // Reads spend one more edge in the RAM
    latency = (e.funct3 == cfu_pkg::op_instr_rd || e.funct3 == cfu_pkg::op_cram_rd) ? 4 : 3;

    // Present the command, previous response must be gone
    @(posedge clk);
    assert (rsp_valid === 1'b0) else begin
      $display("Error: %0t ns entry %0d: rsp_valid still high before the command", $time, idx);
      abort_run();
    end
    cmd_valid <= 1'b1;
    cmd_function_id <= {e.funct7, e.funct3};
    cmd_inputs_0 <= e.in0;
    cmd_inputs_1 <= e.in1;

    // Accepted on the first edge that sees cmd_ready
    cycles = 0;
    @(posedge clk);
    while (cmd_ready !== 1'b1) begin
      cycles++;
      if (cycles > wait_limit) begin
        $display("Timeout: cmd_ready never rose for entry %0d", idx);
        abort_run();
      end
      @(posedge clk);
    end

    // Scrambled bus after acceptance, the DUT works from its own copy
    cmd_valid <= 1'b0;
    cmd_function_id <= 10'($random(seed));
    cmd_inputs_0 <= $random(seed);
    cmd_inputs_1 <= $random(seed);
    rsp_ready <= (e.stall == 4'd0);

    // Edges from acceptance to the first one that sees rsp_valid
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (cycles > wait_limit) begin
        $display("Timeout: rsp_valid never rose for entry %0d", idx);
        abort_run();
      end
      assert (cmd_ready === 1'b0) else begin
        $display("Error: %0t ns entry %0d: cmd_ready high with a command in flight",
                 $time, idx);
        abort_run();
      end
    end while (rsp_valid !== 1'b1);

    assert (cycles == latency) else begin
      $display("Error: %0t ns entry %0d: rsp_valid after %0d cycles, expected %0d",
               $time, idx, cycles, latency);
      abort_run();
    end
    assert (rsp_outputs_0 === e.expected) else begin
      $display("Error: %0t ns entry %0d: rsp_outputs_0 = %h, expected %h",
               $time, idx, rsp_outputs_0, e.expected);
      abort_run();
    end
    held = rsp_outputs_0;

    // rsp_ready low, response and cmd_ready frozen
    for (k = 0; k < int'(e.stall); k++) begin
      @(posedge clk);
      assert (rsp_valid === 1'b1 && rsp_outputs_0 === held && cmd_ready === 1'b0) else begin
        $display("Error: %0t ns entry %0d: response not held under back-pressure", $time, idx);
        abort_run();
      end
    end
    if (e.stall != 4'd0) begin
      rsp_ready <= 1'b1;
      // Completing edge
      @(posedge clk);
      assert (rsp_valid === 1'b1 && rsp_outputs_0 === held) else begin
        $display("Error: %0t ns entry %0d: response dropped before rsp_ready", $time, idx);
        abort_run();
      end
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int idx;
    seed = 32'hee72;
    clk = 1'b0;
    resetn = 1'b0;
    cmd_valid = 1'b0;
    cmd_function_id = 10'd0;
    cmd_inputs_0 = 32'd0;
    cmd_inputs_1 = 32'd0;
    rsp_ready = 1'b0;
    build_table();

    // Reset low for 4 edges
    repeat (4) @(posedge clk);
    resetn <= 1'b1;
    @(posedge clk);
    assert (cmd_ready === 1'b1 && rsp_valid === 1'b0) else begin
      $display("Error: %0t ns: handshake not idle after reset", $time);
      abort_run();
    end

    for (idx = 0; idx < stim_q.size(); idx++) begin
      apply_entry(idx);
    end
    $display("TEST PASS");
    $finish;
  end

endmodule
